// ==== project.f ====
src/stream_pkg.sv
src/stream_fifo.sv
src/stream_switch.sv
src/packet_sender.sv
src/stream_sched_top.sv
testbench/stream_sched_asserts.sv
testbench/stream_sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the stream scheduler testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module stream_sched_tb -o stream_sched_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/stream_sched_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qF "All tests passed!"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== src/packet_sender.sv ====
// output side of the scheduler
// head word mux, pop decode and packet word counter with last marker

`timescale 1ns/1ps

module packet_sender (
	input  logic                                                clock,
	input  logic                                                resetn,
	input  logic                                                grant_valid_i,
	input  logic [stream_pkg::IDX_W-1:0]                        grant_idx_i,
	input  logic [stream_pkg::STREAMS-1:0][stream_pkg::DATA_W-1:0] heads_i,
	input  logic [stream_pkg::STREAMS-1:0]                      empty_i,
	output logic [stream_pkg::STREAMS-1:0]                      pop_o,
	output logic                                                out_valid_o,
	output logic [stream_pkg::DATA_W-1:0]                       out_data_o,
	output logic [stream_pkg::IDX_W-1:0]                        out_stream_o,
	output logic                                                out_last_o,
	input  logic                                                out_ready_i,
	output logic                                                pkt_done_o
);

	logic [stream_pkg::STREAMS-1:0]           grant_onehot;   // decoded grant
	logic [$clog2(stream_pkg::PKT_WORDS)-1:0] word_cnt_q;     // word position in packet
	logic                                     handshake;

	// index to one-hot for the pop bus
	always_comb
	begin
		grant_onehot = '0;
		grant_onehot[grant_idx_i] = 1'b1;
	end

	// ------------------------------
	// output mux
	// ------------------------------
	assign out_valid_o  = grant_valid_i & ~empty_i[grant_idx_i];
	assign out_data_o   = heads_i[grant_idx_i];   // fifo head, held until popped
	assign out_stream_o = grant_idx_i;
	assign out_last_o   = (int'(word_cnt_q) == stream_pkg::PKT_WORDS - 1);

	assign handshake  = out_valid_o & out_ready_i;
	assign pkt_done_o = handshake & out_last_o;          // one cycle pulse
	assign pop_o      = handshake ? grant_onehot : '0;   // no pop under back-pressure

	// word counter, modulo packet length
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			word_cnt_q <= '0;
		else if (handshake)
		begin
			if (out_last_o)
				word_cnt_q <= '0;   // next word opens a packet
			else
				word_cnt_q <= word_cnt_q + 1'b1;
		end
	end

endmodule

// ==== src/stream_fifo.sv ====
// per-stream word fifo
// circular buffer with occupancy count and complete-packet flag

`timescale 1ns/1ps

module stream_fifo (
	input  logic                          clock,
	input  logic                          resetn,
	input  logic                          push_i,
	input  logic [stream_pkg::DATA_W-1:0] push_data_i,
	input  logic                          pop_i,
	output logic [stream_pkg::DATA_W-1:0] head_o,
	output logic                          full_o,
	output logic                          empty_o,
	output logic                          pkt_avail_o
);

	logic [stream_pkg::DATA_W-1:0] mem [stream_pkg::FIFO_DEPTH];   // word storage
	logic [stream_pkg::CNT_W-2:0]  wr_ptr_q;    // next free slot
	logic [stream_pkg::CNT_W-2:0]  rd_ptr_q;    // head slot
	logic [stream_pkg::CNT_W-1:0]  count_q;     // words held
	logic                          do_push;
	logic                          do_pop;

	// pointer step with wrap at depth
	function automatic logic [stream_pkg::CNT_W-2:0] next_ptr(
		input logic [stream_pkg::CNT_W-2:0] ptr
	);
		if (int'(ptr) == stream_pkg::FIFO_DEPTH - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push_i & ~full_o;    // overflow guard
	assign do_pop  = pop_i & ~empty_o;    // underflow guard

	assign full_o      = (int'(count_q) == stream_pkg::FIFO_DEPTH);
	assign empty_o     = (count_q == '0);
	assign pkt_avail_o = (int'(count_q) >= stream_pkg::PKT_WORDS);   // whole packet queued
	assign head_o      = mem[rd_ptr_q];   // first word, shown ahead of pop

	// storage write
	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr_q] <= push_data_i;
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (do_pop)
				rd_ptr_q <= next_ptr(rd_ptr_q);
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;   // idle or both at once
			endcase
		end
	end

endmodule

// ==== src/stream_pkg.sv ====
// sizing constants for the packet stream scheduler
// and the state encoding of the switch fsm

package stream_pkg;

	// ------------------------------
	// stream and word sizing
	// ------------------------------
	localparam int STREAMS   = 8;    // input streams
	localparam int IDX_W     = 3;    // stream index width
	localparam int DATA_W    = 8;    // byte wide words
	localparam int PKT_WORDS = 4;    // fixed packet length

	// ------------------------------
	// fifo and slice sizing
	// ------------------------------
	localparam int FIFO_DEPTH   = 16;   // words per stream fifo
	localparam int CNT_W        = 5;    // holds 0 up to FIFO_DEPTH
	localparam int SLICE_CYCLES = 48;   // grant cycles per slice
	localparam int TIMER_W      = 6;

	// switch fsm states
	typedef enum logic [2:0] {
		S_IDLE,    // waiting for sending_i
		S_LOAD,    // copy mask into rotator
		S_FIND,    // scan one index per cycle
		S_RUN,     // grant held, packet moving
		S_CHECK    // keep stream or move on
	} switch_state_e;

endpackage

// ==== src/stream_sched_top.sv ====
// packet stream scheduler top level
// eight input fifos feeding the switch and the packet sender

`timescale 1ns/1ps

module stream_sched_top (
	input  logic                                                clock,
	input  logic                                                resetn,
	input  logic                                                sending_i,
	input  logic [stream_pkg::STREAMS-1:0]                      stream_mask_i,
	input  logic [stream_pkg::STREAMS-1:0]                      in_valid_i,
	input  logic [stream_pkg::STREAMS-1:0][stream_pkg::DATA_W-1:0] in_data_i,
	output logic [stream_pkg::STREAMS-1:0]                      in_ready_o,
	output logic                                                out_valid_o,
	output logic [stream_pkg::DATA_W-1:0]                       out_data_o,
	output logic [stream_pkg::IDX_W-1:0]                        out_stream_o,
	output logic                                                out_last_o,
	input  logic                                                out_ready_i
);

	logic [stream_pkg::STREAMS-1:0][stream_pkg::DATA_W-1:0] fifo_head;
	logic [stream_pkg::STREAMS-1:0] fifo_full;
	logic [stream_pkg::STREAMS-1:0] fifo_empty;
	logic [stream_pkg::STREAMS-1:0] pkt_avail;   // per-stream complete packet flags
	logic [stream_pkg::STREAMS-1:0] fifo_pop;    // one-hot from sender
	logic                           grant_valid;
	logic [stream_pkg::IDX_W-1:0]   grant_idx;
	logic                           pkt_done;

	// ------------------------------
	// input fifos
	// ------------------------------
	for (genvar k = 0; k < stream_pkg::STREAMS; k++)
	begin : g_fifo
		assign in_ready_o[k] = ~fifo_full[k];   // ready is room left

		stream_fifo u_fifo (
			.clock       (clock),
			.resetn      (resetn),
			.push_i      (in_valid_i[k] & in_ready_o[k]),   // input handshake
			.push_data_i (in_data_i[k]),
			.pop_i       (fifo_pop[k]),
			.head_o      (fifo_head[k]),
			.full_o      (fifo_full[k]),
			.empty_o     (fifo_empty[k]),
			.pkt_avail_o (pkt_avail[k])
		);
	end

	// scheduler
	stream_switch u_switch (
		.clock         (clock),
		.resetn        (resetn),
		.sending_i     (sending_i),
		.stream_mask_i (stream_mask_i),
		.pkt_avail_i   (pkt_avail),
		.pkt_done_i    (pkt_done),
		.grant_valid_o (grant_valid),
		.grant_idx_o   (grant_idx)
	);

	// output port driver
	packet_sender u_sender (
		.clock         (clock),
		.resetn        (resetn),
		.grant_valid_i (grant_valid),
		.grant_idx_i   (grant_idx),
		.heads_i       (fifo_head),
		.empty_i       (fifo_empty),
		.pop_o         (fifo_pop),
		.out_valid_o   (out_valid_o),
		.out_data_o    (out_data_o),
		.out_stream_o  (out_stream_o),
		.out_last_o    (out_last_o),
		.out_ready_i   (out_ready_i),
		.pkt_done_o    (pkt_done)
	);

endmodule

// ==== src/stream_switch.sv ====
// round-robin packet scheduler for the stream mux
// rotating mask copy, stream index counter and slice timer

`timescale 1ns/1ps

module stream_switch (
	input  logic                           clock,
	input  logic                           resetn,
	input  logic                           sending_i,
	input  logic [stream_pkg::STREAMS-1:0] stream_mask_i,
	input  logic [stream_pkg::STREAMS-1:0] pkt_avail_i,
	input  logic                           pkt_done_i,
	output logic                           grant_valid_o,
	output logic [stream_pkg::IDX_W-1:0]   grant_idx_o
);

	stream_pkg::switch_state_e      state_q;
	stream_pkg::switch_state_e      state_d;
	logic [stream_pkg::STREAMS-1:0] rot_q;      // mask copy, bit 0 is stream idx_q
	logic [stream_pkg::IDX_W-1:0]   idx_q;      // stream under test or granted
	logic [stream_pkg::TIMER_W-1:0] timer_q;    // s_run cycles this slice
	logic                           hit;
	logic                           slice_left;
	logic                           keep;
	logic                           advance;

	// enabled and holding a full packet
	assign hit        = rot_q[0] & pkt_avail_i[idx_q];
	assign slice_left = (int'(timer_q) < stream_pkg::SLICE_CYCLES);
	// stay on the same stream after a packet
	assign keep       = sending_i & pkt_avail_i[idx_q] & slice_left;

	// move rotator and index one stream on
	assign advance = ((state_q == stream_pkg::S_FIND) & sending_i & ~hit)
		| ((state_q == stream_pkg::S_CHECK) & ~keep);

	assign grant_valid_o = (state_q == stream_pkg::S_RUN);
	assign grant_idx_o   = idx_q;

	// ------------------------------
	// next state
	// ------------------------------
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			stream_pkg::S_IDLE:
			begin
				if (sending_i)
					state_d = stream_pkg::S_LOAD;
			end
			stream_pkg::S_LOAD:
				state_d = stream_pkg::S_FIND;   // one cycle to load the mask
			stream_pkg::S_FIND:
			begin
				if (!sending_i)
					state_d = stream_pkg::S_IDLE;
				else if (hit)
					state_d = stream_pkg::S_RUN;
			end
			stream_pkg::S_RUN:
			begin
				// packet always finishes, sending_i ignored here
				if (pkt_done_i)
					state_d = stream_pkg::S_CHECK;
			end
			stream_pkg::S_CHECK:
			begin
				if (keep)
					state_d = stream_pkg::S_RUN;    // next packet, same stream
				else
					state_d = stream_pkg::S_FIND;   // index already stepped
			end
			default:
				state_d = stream_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state_q <= stream_pkg::S_IDLE;
		else
			state_q <= state_d;
	end

	// ------------------------------
	// rotating mask and index
	// ------------------------------
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rot_q <= '0;
			idx_q <= '0;
		end
		else if (state_q == stream_pkg::S_IDLE)
		begin
			rot_q <= '0;   // scan restarts at stream 0
			idx_q <= '0;
		end
		else if (state_q == stream_pkg::S_LOAD)
			rot_q <= stream_mask_i;
		else if (advance)
		begin
			rot_q <= {rot_q[0], rot_q[stream_pkg::STREAMS-1:1]};   // right, ascending order
			idx_q <= idx_q + 1'b1;   // wraps 7 to 0 with the rotator
		end
	end

	// slice timer, cleared while scanning
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			timer_q <= '0;
		else if (state_q == stream_pkg::S_FIND)
			timer_q <= '0;
		else if ((state_q == stream_pkg::S_RUN) && !(&timer_q))
			timer_q <= timer_q + 1'b1;   // saturates during long stalls
	end

endmodule

// ==== testbench/stream_sched_asserts.sv ====
// switch fsm assertions, bound into stream_switch
// grant only on a complete packet, stable grant index, pkt_done only in s_run

`timescale 1ns/1ps

module stream_sched_asserts (
	input logic                           clock,
	input logic                           resetn,
	input stream_pkg::switch_state_e      state_i,
	input logic [stream_pkg::STREAMS-1:0] pkt_avail_i,
	input logic                           grant_valid_i,
	input logic [stream_pkg::IDX_W-1:0]   grant_idx_i,
	input logic                           pkt_done_i
);

	int failures = 0;   // failure count, polled from the testbench

	// grant opens only on a stream holding a whole packet
	grant_on_pkt: assert property (@(posedge clock) disable iff (!resetn)
		$rose(grant_valid_i) |-> $past(pkt_avail_i[grant_idx_i]))
	else
	begin
		failures++;
		$error("grant_valid_o rose without a complete packet on the granted stream");
	end

	// index held for the whole run
	idx_stable: assert property (@(posedge clock) disable iff (!resetn)
		(state_i == stream_pkg::S_RUN) |=>
			((state_i != stream_pkg::S_RUN) || $stable(grant_idx_i)))
	else
	begin
		failures++;
		$error("grant index changed during S_RUN");
	end

	// packet end only from a granted stream
	done_in_run: assert property (@(posedge clock) disable iff (!resetn)
		pkt_done_i |-> (state_i == stream_pkg::S_RUN))
	else
	begin
		failures++;
		$error("pkt_done seen outside S_RUN");
	end

endmodule

bind stream_switch stream_sched_asserts u_asserts (
	.clock         (clock),
	.resetn        (resetn),
	.state_i       (state_q),
	.pkt_avail_i   (pkt_avail_i),
	.grant_valid_i (grant_valid_o),
	.grant_idx_i   (grant_idx_o),
	.pkt_done_i    (pkt_done_i)
);

// ==== testbench/stream_sched_tb.sv ====
// testbench for the packet stream scheduler
// lcg driven streams, per-stream reference queues, port checks

`timescale 1ns/1ps

module stream_sched_tb;

	logic                                                   clock;
	logic                                                   resetn;
	logic                                                   sending;
	logic [stream_pkg::STREAMS-1:0]                         stream_mask;
	logic [stream_pkg::STREAMS-1:0]                         in_valid;
	logic [stream_pkg::STREAMS-1:0][stream_pkg::DATA_W-1:0] in_data;
	logic [stream_pkg::STREAMS-1:0]                         in_ready;
	logic                                                   out_valid;
	logic [stream_pkg::DATA_W-1:0]                          out_data;
	logic [stream_pkg::IDX_W-1:0]                           out_stream;
	logic                                                   out_last;
	logic                                                   out_ready;

	// ------------------------------
	// reference model state
	// ------------------------------
	logic [stream_pkg::DATA_W-1:0]  model_q [stream_pkg::STREAMS][$];   // accepted, not sent
	logic [stream_pkg::STREAMS-1:0] in_taken;    // input handshakes at next edge
	logic [stream_pkg::STREAMS-1:0] en_seen;     // mask bit high since last packet
	logic [stream_pkg::STREAMS-1:0] mask_sel;    // mask for the next drive
	logic        send_en;          // sending for the next drive
	logic        feed_on;          // new input words allowed
	logic        prev_sending;
	logic        other_waiting;    // another stream had a packet at run start
	int          heavy_stream;     // stream offered a word every cycle
	int          word_pos;         // word position in the output packet
	int          pkt_stream;
	int          run_stream;       // stream of the consecutive run
	int          run_len;
	int          allowed_starts;   // pending packet when sending fell
	int          starts_off;       // packet starts since sending fell
	int          idle_cycles;      // cycles since the last output word
	logic [31:0] lcg_state;

	always #5 clock = ~clock;

	stream_sched_top dut (
		.clock         (clock),
		.resetn        (resetn),
		.sending_i     (sending),
		.stream_mask_i (stream_mask),
		.in_valid_i    (in_valid),
		.in_data_i     (in_data),
		.in_ready_o    (in_ready),
		.out_valid_o   (out_valid),
		.out_data_o    (out_data),
		.out_stream_o  (out_stream),
		.out_last_o    (out_last),
		.out_ready_i   (out_ready)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h",
				name, actual, expected));
	endtask

	// first word of a packet, mask, sending and slice rules
	task automatic start_packet(input int s);
		int j;
		pkt_stream = s;
		if (!en_seen[s])
			stop_with_failure($sformatf("packet started on masked stream %0d", s));
		en_seen[s] = stream_mask[s];
		if (!sending)
		begin
			starts_off++;
			if (starts_off > allowed_starts)
				stop_with_failure("a new packet started after sending was turned off");
		end
		if (s == run_stream)
			run_len++;
		else
		begin
			run_stream    = s;
			run_len       = 1;
			other_waiting = 1'b0;
			for (j = 0; j < stream_pkg::STREAMS; j++)
				if (j != s && stream_mask[j] && model_q[j].size() >= stream_pkg::PKT_WORDS)
					other_waiting = 1'b1;   // stays pending until served
		end
		if (other_waiting && run_len > stream_pkg::SLICE_CYCLES / stream_pkg::PKT_WORDS + 1)
			stop_with_failure($sformatf("stream %0d kept the output past its time slice", s));
	endtask

	task automatic check_output_word();
		int s;
		logic [stream_pkg::DATA_W-1:0] expected;
		s = int'(out_stream);
		if (word_pos != 0)
			check_value("out_stream_o", out_stream, pkt_stream);   // no interleave
		else
			start_packet(s);
		if (model_q[s].size() == 0)
			stop_with_failure($sformatf("stream %0d sent a word it never accepted", s));
		expected = model_q[s].pop_front();
		check_value("out_data_o", out_data, expected);
		check_value("out_last_o", out_last, word_pos == stream_pkg::PKT_WORDS - 1);
		word_pos = (word_pos + 1) % stream_pkg::PKT_WORDS;
	endtask

	// sampled 1 ns after the falling edge, stable up to the rising edge
	task automatic observe_ports();
		int k;
		if (prev_sending && !sending)
		begin
			allowed_starts = (out_valid && word_pos == 0) ? 1 : 0;   // granted, not started
			starts_off     = 0;
			run_stream     = -1;
			run_len        = 0;
		end
		else if (!prev_sending && sending)
		begin
			run_stream = -1;   // fresh slice once the new mask is loaded
			run_len    = 0;
		end
		prev_sending = sending;
		en_seen      = en_seen | stream_mask;
		if (!sending && out_valid && word_pos == 0 && starts_off >= allowed_starts)
			stop_with_failure("out_valid_o high after sending was off and the last packet ended");
		in_taken = in_valid & in_ready;
		if (out_valid && out_ready)
		begin
			check_output_word();
			idle_cycles = 0;
		end
		else
			idle_cycles++;
		for (k = 0; k < stream_pkg::STREAMS; k++)
			if (in_taken[k])
				model_q[k].push_back(in_data[k]);
		check_value("assertion_failures", dut.u_switch.u_asserts.failures, 0);
	endtask

	task automatic run_cycle();
		logic [31:0] r;
		int k;
		@(negedge clock);
		sending     = send_en;
		stream_mask = mask_sel;
		for (k = 0; k < stream_pkg::STREAMS; k++)
		begin
			if (!in_valid[k] || in_taken[k])   // hold a word until taken
			begin
				r = next_random();
				in_valid[k] = feed_on && (k == heavy_stream || r[31:30] == 2'b00);
				in_data[k]  = r[23:16];
			end
		end
		r = next_random();
		out_ready = (r[31:30] != 2'b00);   // about 3 in 4
		#1;
		observe_ports();
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		int   phase;
		int   cycles;
		int   k;
		logic drained;
		clock = 1'b0;
		resetn = 1'b0;
		sending = 1'b0;
		stream_mask = '0;
		in_valid = '0;
		in_data = '0;
		out_ready = 1'b0;
		mask_sel = '0;
		send_en = 1'b0;
		feed_on = 1'b0;
		prev_sending = 1'b0;
		other_waiting = 1'b0;
		heavy_stream = -1;
		in_taken = '0;
		en_seen = '0;
		word_pos = 0;
		pkt_stream = 0;
		run_stream = -1;
		run_len = 0;
		allowed_starts = 0;
		starts_off = 0;
		idle_cycles = 0;
		lcg_state = 32'h9016_287b;

		repeat (2) @(posedge clock);
		@(negedge clock);
		resetn = 1'b1;
		#1;
		check_value("in_ready_o", in_ready, (1 << stream_pkg::STREAMS) - 1);
		check_value("out_valid_o", out_valid, 0);

		for (phase = 0; phase < 6; phase++)
		begin
			// one enabled stream fed every cycle so its slice can run out
			heavy_stream = phase;
			// new mask only while sending is off and the switch is idle
			mask_sel = (phase == 0) ? '1 : (next_random() >> 24) | (1 << phase);
			send_en  = 1'b1;
			feed_on  = 1'b1;
			repeat (400) run_cycle();
			send_en = 1'b0;
			cycles  = 0;
			do
			begin
				run_cycle();
				cycles++;
				if (cycles > 500)
					stop_with_failure("output did not go idle after sending was turned off");
			end
			while (!(cycles >= 8 && idle_cycles >= 4 && word_pos == 0
				&& starts_off >= allowed_starts));
		end

		// drain every complete packet with all streams enabled
		mask_sel = '1;
		send_en  = 1'b1;
		feed_on  = 1'b0;
		cycles   = 0;
		drained  = 1'b0;
		while (!drained)
		begin
			run_cycle();
			cycles++;
			if (cycles > 4000)
				stop_with_failure("queued complete packets did not drain in time");
			drained = (in_valid == '0) && (word_pos == 0);
			for (k = 0; k < stream_pkg::STREAMS; k++)
				if (model_q[k].size() >= stream_pkg::PKT_WORDS)
					drained = 1'b0;
		end

		if (dut.u_switch.u_asserts.failures != 0)
			stop_with_failure("switch assertions reported failures");
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
